// ==== src/fetch_config.svh ====
// Sizes are fixed for four harts and a 16-line cache; FETCH_INDEX_W must match FETCH_CACHE_LINES
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

////////////////////
// Datapath
////////////////////
`define FETCH_WORD_W      32                // Address and instruction width

////////////////////
// Harts
////////////////////
`define FETCH_HART_NUM    4                 // Barrel depth
`define FETCH_HART_ID_W   2                 // Hart id width

////////////////////
// Instruction cache
////////////////////
`define FETCH_CACHE_LINES 16                // One word per line
`define FETCH_INDEX_W     4                 // Line index from pc[5:2]
`define FETCH_MISS_CYCLES 6                 // Refill latency in cycles

////////////////////
// Instruction words
////////////////////
`define FETCH_OP_NOP      32'h0000_0013     // addi x0, x0, 0
`define FETCH_INSN_SALT   32'h5a3c_0f00     // Refill word is address XOR salt

`endif

// ==== src/fetch_pkg.sv ====
// Enum widths are fixed here and do not follow the hart count in the config header
package fetch_pkg;

    ////////////////////
    // Hart scheduling
    ////////////////////
    typedef enum logic [1:0] {
        HART_IDLE   = 2'd0,     // Not started
        HART_ACTIVE = 2'd1,     // Runnable
        HART_PEND   = 2'd2      // Waiting on refill
    } hart_state_t;

    ////////////////////
    // IF/ID events
    ////////////////////
    typedef enum logic [2:0] {
        EVT_HOLD   = 3'd0,      // Stall, nothing moves
        EVT_FLUSH  = 3'd1,      // Issuing hart redirected to new_pc
        EVT_MISS   = 3'd2,      // Cache miss, PC kept for retry
        EVT_BRANCH = 3'd3,      // Branch redirect of br_hart_id
        EVT_SEQ    = 3'd4,      // Normal PC+4 fetch
        EVT_BUBBLE = 3'd5       // No runnable hart
    } fetch_evt_t;

endpackage

// ==== src/hart_sched.sv ====
// Round-robin over active harts only; a miss is parked only when the refill timer is idle
`timescale 1ns/1ps
`include "fetch_config.svh"

module hart_sched import fetch_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                stall,          // Decode back-pressure
    input  logic                                hs_start,       // Hart start request
    input  logic [`FETCH_HART_ID_W-1:0]         hs_id,          // Hart to start
    input  logic                                miss,           // Cache miss on fetch_pc
    input  logic                                busy,           // Refill in progress
    input  logic                                fill_done,      // Refill complete
    input  logic [`FETCH_HART_ID_W-1:0]         fill_hart,      // Hart that was refilled
    output logic                                issue,          // A hart fetches this cycle
    output logic [`FETCH_HART_ID_W-1:0]         issue_hart,     // Which one
    output logic                                start_ok,       // Start accepted
    output logic                                miss_accept,    // Miss handed to timer
    output hart_state_t [`FETCH_HART_NUM-1:0]   hart_state_vec  // Debug view
);

    hart_state_t [`FETCH_HART_NUM-1:0] state_q;     // Per-hart state
    logic [`FETCH_HART_ID_W-1:0]       last_q;      // Last issued hart
    logic [`FETCH_HART_ID_W-1:0]       cand;        // Search candidate
    logic                              found;       // Some hart is active

    assign hart_state_vec = state_q;

    ////////////////////
    // Selection
    ////////////////////
    // Scan from the hart after the last issued one and take the first active
    always_comb begin
        found      = 1'b0;
        issue_hart = last_q;
        cand       = last_q;
        for (int i = 1; i <= `FETCH_HART_NUM; i++) begin
            cand = last_q + `FETCH_HART_ID_W'(i);            // Wraps naturally
            if (!found && state_q[cand] == HART_ACTIVE) begin
                found      = 1'b1;
                issue_hart = cand;
            end
        end
    end

    assign issue       = found && !stall;                   // Nothing issues under stall
    assign miss_accept = issue && miss && !busy;            // One refill at a time
    assign start_ok    = hs_start && state_q[hs_id] == HART_IDLE &&
                         !(issue && issue_hart == hs_id);

    ////////////////////
    // State and pointer
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= `FETCH_HART_ID_W'(`FETCH_HART_NUM - 1); // Hart 0 goes first
            for (int h = 0; h < `FETCH_HART_NUM; h++) begin
                state_q[h] <= HART_IDLE;
            end
        end else begin
            if (issue) begin
                last_q <= issue_hart;                       // Pointer holds under stall
            end
            for (int h = 0; h < `FETCH_HART_NUM; h++) begin
                if (fill_done && fill_hart == `FETCH_HART_ID_W'(h)) begin
                    state_q[h] <= HART_ACTIVE;              // Back from refill
                end else if (miss_accept && issue_hart == `FETCH_HART_ID_W'(h)) begin
                    state_q[h] <= HART_PEND;                // Park the missing hart
                end else if (start_ok && hs_id == `FETCH_HART_ID_W'(h)) begin
                    state_q[h] <= HART_ACTIVE;
                end
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    a_issue_active: assert property (@(posedge clk) disable iff (!rst_n)
        issue |-> state_q[issue_hart] == HART_ACTIVE);

    // Refill completion and issue never name the same hart
    a_fill_not_issued: assert property (@(posedge clk) disable iff (!rst_n)
        fill_done && issue |-> fill_hart != issue_hart);

endmodule

// ==== src/refill_timer.sv ====
// Only one refill can be outstanding; a miss arriving while busy must be dropped by the caller
`timescale 1ns/1ps
`include "fetch_config.svh"

module refill_timer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          miss_accept,  // Start a refill
    input  logic [`FETCH_HART_ID_W-1:0]   miss_hart,    // Requesting hart
    input  logic [`FETCH_WORD_W-1:0]      miss_addr,    // Missed PC
    output logic                          busy,         // Refill running
    output logic                          fill_done,    // Last refill cycle
    output logic [`FETCH_HART_ID_W-1:0]   fill_hart,
    output logic [`FETCH_WORD_W-1:0]      fill_addr
);

    localparam int CNT_W = $clog2(`FETCH_MISS_CYCLES + 1);

    logic [CNT_W-1:0] cnt_q;                            // Remaining cycles

    assign busy      = cnt_q != '0;
    assign fill_done = cnt_q == CNT_W'(1);              // Expires at this edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (miss_accept) begin
            cnt_q <= CNT_W'(`FETCH_MISS_CYCLES);
        end else if (busy) begin
            cnt_q <= cnt_q - CNT_W'(1);
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (miss_accept) begin
            fill_hart <= miss_hart;
            fill_addr <= miss_addr;
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        miss_accept |-> !busy);

endmodule

// ==== src/insn_cache.sv ====
// Data is not stored; a hit returns fetch_pc XOR salt, standing in for a real memory
`timescale 1ns/1ps
`include "fetch_config.svh"

module insn_cache (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`FETCH_WORD_W-1:0]   fetch_pc,    // Lookup address
    input  logic                       fill_done,   // Refill completes
    input  logic [`FETCH_WORD_W-1:0]   fill_addr,   // Address being filled
    output logic [`FETCH_WORD_W-1:0]   insn,        // Fetched word
    output logic                       miss         // Lookup missed
);

    localparam int TAG_W = `FETCH_WORD_W - `FETCH_INDEX_W - 2;

    logic [`FETCH_CACHE_LINES-1:0] valid_q;                 // Line valid bits
    logic [TAG_W-1:0]              tag_q [`FETCH_CACHE_LINES];

    logic [`FETCH_INDEX_W-1:0] fetch_idx;
    logic [TAG_W-1:0]          fetch_tag;
    logic [`FETCH_INDEX_W-1:0] fill_idx;
    logic                      hit;

    ////////////////////
    // Lookup
    ////////////////////
    assign fetch_idx = fetch_pc[`FETCH_INDEX_W+1:2];        // Word aligned
    assign fetch_tag = fetch_pc[`FETCH_WORD_W-1:`FETCH_INDEX_W+2];
    assign fill_idx  = fill_addr[`FETCH_INDEX_W+1:2];

    assign hit  = valid_q[fetch_idx] && tag_q[fetch_idx] == fetch_tag;
    assign miss = !hit;
    assign insn = hit ? (fetch_pc ^ `FETCH_INSN_SALT) : `FETCH_OP_NOP;

    ////////////////////
    // Fill
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;                                  // All lines invalid
        end else if (fill_done) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_q[fill_idx] <= fill_addr[`FETCH_WORD_W-1:`FETCH_INDEX_W+2];
        end
    end

    // A hit word comes only from a filled line
    a_hit_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !miss |-> valid_q[fetch_idx]);

endmodule

// ==== src/if_reg.sv ====
// Redirect priority is flush, miss, branch, PC+4; a miss drops a branch aimed at the same hart
`timescale 1ns/1ps
`include "fetch_config.svh"

module if_reg import fetch_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,        // Hold everything
    input  logic                          flush,        // Redirect issuing hart
    input  logic [`FETCH_WORD_W-1:0]      new_pc,       // Flush target
    input  logic                          issue,        // A hart fetches
    input  logic [`FETCH_HART_ID_W-1:0]   issue_hart,
    input  logic [`FETCH_WORD_W-1:0]      insn,         // Cache word
    input  logic                          miss,         // Cache miss
    input  logic                          br_taken,
    input  logic [`FETCH_HART_ID_W-1:0]   br_hart_id,
    input  logic [`FETCH_WORD_W-1:0]      br_addr,
    input  logic                          start_ok,     // Start accepted by scheduler
    input  logic [`FETCH_HART_ID_W-1:0]   hs_id,
    input  logic [`FETCH_WORD_W-1:0]      hs_pc,
    output logic [`FETCH_WORD_W-1:0]      fetch_pc,     // Selected hart's PC
    output logic [`FETCH_WORD_W-1:0]      if_pc_q,
    output logic [`FETCH_WORD_W-1:0]      if_npc,
    output logic [`FETCH_WORD_W-1:0]      if_insn,
    output logic                          if_en,        // Valid to decode
    output logic [`FETCH_HART_ID_W-1:0]   if_hart_id
);

    logic [`FETCH_WORD_W-1:0] pc_q [`FETCH_HART_NUM];       // Per-hart PC file
    logic [`FETCH_WORD_W-1:0] npc;
    logic [`FETCH_WORD_W-1:0] issue_pc_d;                   // Next PC of issuing hart
    logic                     br_own;                       // Branch hits issuing hart
    logic                     out_valid;
    fetch_evt_t               evt;

    assign fetch_pc = pc_q[issue_hart];
    assign npc      = fetch_pc + `FETCH_WORD_W'(4);
    assign br_own   = br_hart_id == issue_hart;

    ////////////////////
    // Event decode
    ////////////////////
    always_comb begin
        if (stall)                evt = EVT_HOLD;
        else if (flush)           evt = EVT_FLUSH;
        else if (issue && miss)   evt = EVT_MISS;
        else if (br_taken)        evt = EVT_BRANCH;
        else if (issue)           evt = EVT_SEQ;
        else                      evt = EVT_BUBBLE;
    end

    always_comb begin
        case (evt)
            EVT_FLUSH:  issue_pc_d = new_pc;
            EVT_MISS:   issue_pc_d = fetch_pc;              // Retry after refill
            EVT_BRANCH: issue_pc_d = br_own ? br_addr : npc;
            default:    issue_pc_d = npc;
        endcase
    end

    // Branch to another hart still lets this fetch through
    assign out_valid = issue && (evt == EVT_SEQ || (evt == EVT_BRANCH && !br_own));

    ////////////////////
    // PC file
    ////////////////////
    // Start writes even under stall so it stays in step with the scheduler
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int h = 0; h < `FETCH_HART_NUM; h++) begin
                pc_q[h] <= '0;
            end
        end else begin
            for (int h = 0; h < `FETCH_HART_NUM; h++) begin
                if (start_ok && hs_id == `FETCH_HART_ID_W'(h)) begin
                    pc_q[h] <= hs_pc;
                end else if (!stall) begin
                    if (issue && issue_hart == `FETCH_HART_ID_W'(h)) begin
                        pc_q[h] <= issue_pc_d;
                    end else if (br_taken && br_hart_id == `FETCH_HART_ID_W'(h)) begin
                        pc_q[h] <= br_addr;                 // Idle or parked hart
                    end
                end
            end
        end
    end

    ////////////////////
    // IF/ID register
    ////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_en      <= 1'b0;
            if_hart_id <= '0;
        end else if (evt != EVT_HOLD) begin
            if_en      <= out_valid;
            if_hart_id <= issue_hart;
        end
    end

    always_ff @(posedge clk) begin
        if (evt != EVT_HOLD) begin
            if_pc_q <= out_valid ? fetch_pc : '0;
            if_npc  <= out_valid ? npc : '0;
            if_insn <= out_valid ? insn : `FETCH_OP_NOP;    // NOP in bubbles
        end
    end

    a_npc_step: assert property (@(posedge clk) disable iff (!rst_n)
        if_en |-> if_npc == if_pc_q + `FETCH_WORD_W'(4));

endmodule

// ==== src/fetch_top.sv ====
// Branch and flush are plain pulses from outside; there is no memory bus behind the cache
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_top import fetch_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                stall,
    input  logic                                flush,
    input  logic [`FETCH_WORD_W-1:0]            new_pc,
    input  logic                                br_taken,
    input  logic [`FETCH_HART_ID_W-1:0]         br_hart_id,
    input  logic [`FETCH_WORD_W-1:0]            br_addr,
    input  logic                                hs_start,
    input  logic [`FETCH_HART_ID_W-1:0]         hs_id,
    input  logic [`FETCH_WORD_W-1:0]            hs_pc,
    output logic [`FETCH_WORD_W-1:0]            if_pc_q,
    output logic [`FETCH_WORD_W-1:0]            if_npc,
    output logic [`FETCH_WORD_W-1:0]            if_insn,
    output logic                                if_en,
    output logic [`FETCH_HART_ID_W-1:0]         if_hart_id,
    output hart_state_t [`FETCH_HART_NUM-1:0]   hart_state_vec
);

    logic                          issue;
    logic [`FETCH_HART_ID_W-1:0]   issue_hart;
    logic                          start_ok;        // Shared start rule
    logic                          miss_accept;
    logic                          busy;
    logic                          fill_done;
    logic [`FETCH_HART_ID_W-1:0]   fill_hart;
    logic [`FETCH_WORD_W-1:0]      fill_addr;
    logic [`FETCH_WORD_W-1:0]      fetch_pc;        // PC under lookup
    logic [`FETCH_WORD_W-1:0]      insn;
    logic                          miss;

    hart_sched hart_sched_i (
        .clk, .rst_n, .stall, .hs_start, .hs_id, .miss, .busy, .fill_done, .fill_hart,
        .issue, .issue_hart, .start_ok, .miss_accept, .hart_state_vec
    );

    refill_timer refill_timer_i (
        .clk, .rst_n, .miss_accept,
        .miss_hart (issue_hart),
        .miss_addr (fetch_pc),
        .busy, .fill_done, .fill_hart, .fill_addr
    );

    insn_cache insn_cache_i (
        .clk, .rst_n, .fetch_pc, .fill_done, .fill_addr, .insn, .miss
    );

    if_reg if_reg_i (
        .clk, .rst_n, .stall, .flush, .new_pc, .issue, .issue_hart, .insn, .miss,
        .br_taken, .br_hart_id, .br_addr, .start_ok, .hs_id, .hs_pc,
        .fetch_pc, .if_pc_q, .if_npc, .if_insn, .if_en, .if_hart_id
    );

endmodule

// ==== verif/fetch_tb.sv ====
// Reference model assumes one hart is active whenever flush is driven and branches only hit parked harts
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int CLK_NS    = 20;
    localparam int LEN_RESET = 20;                      // Test lengths in cycles
    localparam int LEN_SEQ   = 230;
    localparam int LEN_MISS  = 35;
    localparam int LEN_RR    = 280;
    localparam int LEN_REDIR = 75;
    localparam int LEN_STALL = 235;
    localparam int WATCHDOG_NS =
        (LEN_RESET + LEN_SEQ + LEN_MISS + LEN_RR + LEN_REDIR + LEN_STALL) * 2 * CLK_NS;
    localparam logic [31:0] RAND_SEED = 32'h4d15_1437;

    logic                              clk;
    logic                              rst_n;
    logic                              stall;
    logic                              flush;
    logic [`FETCH_WORD_W-1:0]          new_pc;
    logic                              br_taken;
    logic [`FETCH_HART_ID_W-1:0]       br_hart_id;
    logic [`FETCH_WORD_W-1:0]          br_addr;
    logic                              hs_start;
    logic [`FETCH_HART_ID_W-1:0]       hs_id;
    logic [`FETCH_WORD_W-1:0]          hs_pc;
    logic [`FETCH_WORD_W-1:0]          if_pc_q;
    logic [`FETCH_WORD_W-1:0]          if_npc;
    logic [`FETCH_WORD_W-1:0]          if_insn;
    logic                              if_en;
    logic [`FETCH_HART_ID_W-1:0]       if_hart_id;
    hart_state_t [`FETCH_HART_NUM-1:0] hart_state_vec;

    logic [`FETCH_HART_ID_W-1:0]       flush_hart;      // Hart known to issue under flush
    logic [`FETCH_WORD_W-1:0]          exp_pc [`FETCH_HART_NUM];   // Next expected PC
    int                                out_cnt [`FETCH_HART_NUM];
    logic [`FETCH_HART_NUM-1:0]        started;
    logic                              started_any;
    logic                              all_idle;
    logic                              out_new;         // Output was written last edge
    logic                              prev_valid;
    logic [`FETCH_HART_ID_W-1:0]       prev_id;
    hart_state_t [`FETCH_HART_NUM-1:0] st_d;            // Hart states one cycle back

    string cur_test = "none";
    int    err_cnt  = 0;
    int    err_start;
    int    test_cnt = 0;
    int    fail_cnt = 0;

    fetch_top dut_i (.*);

    always #(CLK_NS / 2) clk = ~clk;

    ////////////////////
    // Reference model
    ////////////////////
    assign started_any = |started;

    always_comb begin
        all_idle = 1'b1;
        for (int h = 0; h < `FETCH_HART_NUM; h++) begin
            if (hart_state_vec[h] != HART_IDLE) begin
                all_idle = 1'b0;
            end
        end
    end

    // Later writes win: output step, then branch, flush, start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int h = 0; h < `FETCH_HART_NUM; h++) begin
                exp_pc[h]  <= '0;
                out_cnt[h] <= 0;
                st_d[h]    <= HART_IDLE;
            end
            started    <= '0;
            out_new    <= 1'b0;
            prev_valid <= 1'b0;
            prev_id    <= '0;
        end else begin
            out_new    <= !stall;
            prev_valid <= if_en && out_new;
            prev_id    <= if_hart_id;
            st_d       <= hart_state_vec;
            if (if_en && out_new) begin
                exp_pc[if_hart_id]  <= exp_pc[if_hart_id] + `FETCH_WORD_W'(4);
                out_cnt[if_hart_id] <= out_cnt[if_hart_id] + 1;
            end
            if (br_taken && !stall) begin
                exp_pc[br_hart_id] <= br_addr;
            end
            if (flush && !stall) begin
                exp_pc[flush_hart] <= new_pc;
            end
            if (hs_start && !started[hs_id]) begin  // Start only lands on an idle hart
                exp_pc[hs_id]  <= hs_pc;
                started[hs_id] <= 1'b1;
            end
        end
    end

    // First active hart after the last issued one
    function automatic logic [`FETCH_HART_ID_W-1:0] rr_next(
        input logic [`FETCH_HART_ID_W-1:0]       last,
        input hart_state_t [`FETCH_HART_NUM-1:0] st
    );
        logic [`FETCH_HART_ID_W-1:0] c;
        rr_next = last;
        for (int i = `FETCH_HART_NUM; i >= 1; i--) begin
            c = last + `FETCH_HART_ID_W'(i);
            if (st[c] == HART_ACTIVE) begin
                rr_next = c;
            end
        end
    endfunction

    task automatic log_mismatch(input string what, input logic [`FETCH_WORD_W-1:0] exp_v,
                                input logic [`FETCH_WORD_W-1:0] act_v);
        err_cnt++;
        $display("Error %s: %s expected %h actual %h", cur_test, what, exp_v, act_v);
    endtask

    task automatic log_failure(input string msg);
        err_cnt++;
        $display("Test %s: %s", cur_test, msg);
    endtask

    ////////////////////
    // Checks
    ////////////////////
    a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !started_any |-> !if_en && all_idle)
        else log_failure("decode saw an output or a hart left idle before any start");

    a_insn_rule: assert property (@(posedge clk) disable iff (!rst_n)
        if_en |-> if_insn == (if_pc_q ^ `FETCH_INSN_SALT))
        else log_mismatch("if_insn", $sampled(if_pc_q) ^ `FETCH_INSN_SALT, $sampled(if_insn));

    a_npc_rule: assert property (@(posedge clk) disable iff (!rst_n)
        if_en |-> if_npc == if_pc_q + `FETCH_WORD_W'(4))
        else log_mismatch("if_npc", $sampled(if_pc_q) + `FETCH_WORD_W'(4), $sampled(if_npc));

    a_pc_seq: assert property (@(posedge clk) disable iff (!rst_n)
        if_en && out_new |-> if_pc_q == exp_pc[if_hart_id])
        else log_mismatch("if_pc_q", $sampled(exp_pc[if_hart_id]), $sampled(if_pc_q));

    a_round_robin: assert property (@(posedge clk) disable iff (!rst_n)
        if_en && out_new && prev_valid |-> if_hart_id == rr_next(prev_id, st_d))
        else log_mismatch("if_hart_id",
                          `FETCH_WORD_W'(rr_next($sampled(prev_id), $sampled(st_d))),
                          `FETCH_WORD_W'($sampled(if_hart_id)));

    a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        flush && !stall |=> !if_en)
        else log_mismatch("if_en after flush", '0, `FETCH_WORD_W'($sampled(if_en)));

    a_stall_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(if_en) && $stable(if_pc_q) && $stable(if_npc) &&
                  $stable(if_insn) && $stable(if_hart_id))
        else log_failure("IF/ID outputs changed while stall was high");

    for (genvar g = 0; g < `FETCH_HART_NUM; g++) begin : g_hart_chk
        a_park_bubble: assert property (@(posedge clk) disable iff (!rst_n)
            hart_state_vec[g] == HART_PEND && st_d[g] != HART_PEND
            |-> !(if_en && if_hart_id == `FETCH_HART_ID_W'(g)))
            else log_failure($sformatf("hart %0d missed but its fetch reached decode", g));

        a_refill_time: assert property (@(posedge clk) disable iff (!rst_n)
            hart_state_vec[g] == HART_PEND && st_d[g] != HART_PEND
            |-> (hart_state_vec[g] == HART_PEND) [*`FETCH_MISS_CYCLES]
                ##1 hart_state_vec[g] == HART_ACTIVE)
            else log_failure($sformatf("hart %0d did not come back after the refill time", g));
    end

    ////////////////////
    // Stimulus helpers
    ////////////////////
    task automatic step();
        @(posedge clk);
        #2;                                             // Drive after the edge
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
    endtask

    task automatic start_hart(input int h, input logic [`FETCH_WORD_W-1:0] pc);
        hs_start = 1'b1;
        hs_id    = `FETCH_HART_ID_W'(h);
        hs_pc    = pc;
        step();
        hs_start = 1'b0;
    endtask

    task automatic take_branch(input int h, input logic [`FETCH_WORD_W-1:0] target);
        br_taken   = 1'b1;
        br_hart_id = `FETCH_HART_ID_W'(h);
        br_addr    = target;
        step();
        br_taken   = 1'b0;
    endtask

    task automatic wait_state(input int h, input hart_state_t st, input int limit);
        int n = 0;
        while (hart_state_vec[h] != st && n < limit) begin
            step();
            n++;
        end
        if (hart_state_vec[h] != st) begin
            log_failure($sformatf("hart %0d never reached %s within %0d cycles",
                                  h, st.name(), limit));
        end
    endtask

    // Target is an absolute output count for the hart
    task automatic wait_outputs(input int h, input int target, input int limit);
        int n = 0;
        while (out_cnt[h] < target && n < limit) begin
            step();
            n++;
        end
        if (out_cnt[h] < target) begin
            log_failure($sformatf("hart %0d gave %0d of %0d outputs within %0d cycles",
                                  h, out_cnt[h], target, limit));
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        err_start = err_cnt;
        test_cnt++;
        apply_reset();
    endtask

    task automatic end_test();
        if (err_cnt == err_start) begin
            $display("Test %s: pass", cur_test);
        end else begin
            fail_cnt++;
            $display("Test %s: fail with %0d errors", cur_test, err_cnt - err_start);
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////
    initial begin
        int base [`FETCH_HART_NUM];
        clk        = 1'b0;
        rst_n      = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        new_pc     = '0;
        br_taken   = 1'b0;
        br_hart_id = '0;
        br_addr    = '0;
        hs_start   = 1'b0;
        hs_id      = '0;
        hs_pc      = '0;
        flush_hart = '0;
        void'($urandom(RAND_SEED));

        begin_test("reset");                            // Quiet until first start
        repeat (10) step();
        end_test();

        begin_test("seq_fetch");
        start_hart(0, 32'h0000_0100);
        wait_outputs(0, out_cnt[0] + 8, 160);           // Cold lines 0..7
        wait_state(0, HART_PEND, 20);
        take_branch(0, 32'h0000_0100);                  // Rerun over warm lines
        wait_outputs(0, out_cnt[0] + 8, 40);
        end_test();

        begin_test("miss_refill");
        start_hart(1, 32'h0000_2000);
        wait_state(1, HART_PEND, 10);
        wait_state(1, HART_ACTIVE, 12);
        wait_outputs(1, out_cnt[1] + 1, 5);
        end_test();

        begin_test("interleave");
        start_hart(0, 32'h0000_0400);                   // Warm lines 0..15 alone
        wait_outputs(0, out_cnt[0] + 16, 200);
        start_hart(1, 32'h0000_0410);                   // Others hit back to back
        start_hart(2, 32'h0000_0420);
        start_hart(3, 32'h0000_0430);
        for (int h = 1; h < `FETCH_HART_NUM; h++) begin
            base[h] = out_cnt[h];
        end
        wait_outputs(1, base[1] + 4, 30);
        for (int h = 2; h < `FETCH_HART_NUM; h++) begin
            wait_outputs(h, base[h] + 4, 20);
        end
        end_test();

        begin_test("branch_flush");
        start_hart(2, 32'h0000_3000);
        wait_state(2, HART_PEND, 10);
        take_branch(2, 32'h0001_0000 | ($urandom & 32'h0000_fffc));
        wait_outputs(2, out_cnt[2] + 1, 20);
        wait_state(2, HART_ACTIVE, 20);                 // Hart 2 alone, so it issues now
        flush      = 1'b1;
        flush_hart = 2'd2;
        new_pc     = 32'h0002_0000 | ($urandom & 32'h0000_fffc);
        step();
        flush      = 1'b0;
        wait_outputs(2, out_cnt[2] + 1, 20);
        end_test();

        begin_test("stall_start");
        start_hart(0, 32'h0000_0100);
        start_hart(3, 32'h0000_0520);
        wait_outputs(0, out_cnt[0] + 2, 60);
        stall = 1'b1;
        repeat (2) step();
        start_hart(0, 32'hdead_0000);                   // Hart 0 busy, ignored
        repeat (3) step();
        stall = 1'b0;
        start_hart(3, 32'hbeef_0000);                   // Hart 3 busy, ignored
        wait_outputs(0, out_cnt[0] + 3, 80);
        wait_outputs(3, out_cnt[3] + 3, 80);
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, test %s is stuck", WATCHDOG_NS, cur_test);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+src
src/fetch_pkg.sv
src/hart_sched.sv
src/refill_timer.sv
src/insn_cache.sv
src/if_reg.sv
src/fetch_top.sv
verif/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the fetch front-end testbench with Verilator, run it and check for the pass line
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb \
        -f sources.f -o fetch_sim; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

if ! sim_out="$(./obj_dir/fetch_sim)"; then
    echo "$sim_out"
    echo "run.sh: simulation exited with an error status"
    exit 1
fi
echo "$sim_out"

if grep -qx "ALL TESTS PASSED" <<< "$sim_out"; then
    exit 0
fi

echo "run.sh: pass line not found in simulation output"
exit 1
